//--- src/pusch_dr_params.svh
//--------------------------------------------------------------------
// PUSCH dimension reduction constants
// lane, antenna and beam counts, FIFO depth and field widths
//--------------------------------------------------------------------
`ifndef PUSCH_DR_PARAMS_SVH
`define PUSCH_DR_PARAMS_SVH

`define DR_LANES         2      // cpri receive lanes
`define DR_ANT_PER_LANE  2      // antennas per 64-bit IQ word
`define DR_ANT           4      // total antennas
`define DR_BEAM          2      // output beams
`define DR_IQ_W          16     // I or Q width
`define DR_PWR_W         32     // beam power accumulator, wraps
`define DR_SKEW_DEPTH    4      // per-lane de-skew FIFO depth
`define DR_LEN_W         11     // IQ word count field

`endif

//--- src/cpri_pkg.sv
//--------------------------------------------------------------------
// CPRI side types
// lane words, packet header layout, packet type and unpack state
//--------------------------------------------------------------------
`include "pusch_dr_params.svh"

package cpri_pkg;

    typedef struct packed {
        logic [63:0] data;
        logic        vld;
    } cpri_rx_t;

    typedef struct packed {
        logic [63:0] data;
        logic        vld;
    } cpri_tx_t;

    // packet type, carried through to the tx header
    typedef enum logic [3:0] {
        UL_DATA  = 4'd0,
        UL_SRS   = 4'd1,
        UL_PRACH = 4'd2
    } pkg_type_e;

    typedef struct packed {
        pkg_type_e              pkg_type;
        logic [6:0]             slot_idx;
        logic [3:0]             symb_idx;
        logic                   cell_idx;
        logic [7:0]             fft_agc;
        logic [`DR_LEN_W-1:0]   iq_cnt;     // IQ words after header
        logic [28:0]            rsvd;       // zero
    } cpri_hdr_t;

    typedef enum logic {ST_HDR, ST_IQ} unpack_st_e;

endpackage

//--- src/dr_pkg.sv
//--------------------------------------------------------------------
// dimension reduction types
// IQ sample, antenna and beam vectors, per-packet info
//--------------------------------------------------------------------
`include "pusch_dr_params.svh"

package dr_pkg;
    import cpri_pkg::*;

    typedef struct packed {
        logic signed [`DR_IQ_W-1:0] i;
        logic signed [`DR_IQ_W-1:0] q;
    } iq_t;

    typedef iq_t [`DR_ANT-1:0]  ant_vec_t;      // ant 0 in low bits
    typedef iq_t [`DR_BEAM-1:0] beam_vec_t;     // one tx data word

    // header without the count
    typedef struct packed {
        pkg_type_e  pkg_type;
        logic [6:0] slot_idx;
        logic [3:0] symb_idx;
        logic       cell_idx;
        logic [7:0] fft_agc;
    } pkt_info_t;

endpackage

//--- src/cpri_rx_unpack.sv
//--------------------------------------------------------------------
// CPRI receive lane unpacker
// splits the header word from the IQ words and flags the last IQ word
//--------------------------------------------------------------------
`include "pusch_dr_params.svh"

module cpri_rx_unpack
    import cpri_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  cpri_rx_t    i_rx,
    output logic        o_hdr_vld,      // one cycle per header
    output cpri_hdr_t   o_hdr,
    output logic        o_iq_vld,
    output logic [63:0] o_iq_data,
    output logic        o_iq_last
);

    unpack_st_e             st;
    logic [`DR_LEN_W-1:0]   iq_left;    // IQ words still to come
    cpri_hdr_t              rx_hdr;

    assign rx_hdr = cpri_hdr_t'(i_rx.data);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            st        <= ST_HDR;
            iq_left   <= '0;
            o_hdr_vld <= 1'b0;
            o_iq_vld  <= 1'b0;
            o_iq_last <= 1'b0;
        end else begin
            o_hdr_vld <= 1'b0;
            o_iq_vld  <= 1'b0;
            o_iq_last <= 1'b0;
            if (i_rx.vld) begin
                case (st)
                    ST_HDR: begin
                        o_hdr_vld <= 1'b1;
                        iq_left   <= rx_hdr.iq_cnt;
                        if (rx_hdr.iq_cnt != '0)
                            st <= ST_IQ;    // empty packet stays here
                    end
                    ST_IQ: begin
                        o_iq_vld <= 1'b1;
                        iq_left  <= iq_left - 1'b1;
                        if (iq_left == `DR_LEN_W'(1)) begin
                            o_iq_last <= 1'b1;
                            st        <= ST_HDR;
                        end
                    end
                    default: st <= ST_HDR;
                endcase
            end
        end
    end

    // payload capture
    always_ff @(posedge i_clk) begin
        if (i_rx.vld) begin
            if (st == ST_HDR)
                o_hdr <= rx_hdr;
            else
                o_iq_data <= i_rx.data;
        end
    end

endmodule

//--- src/cpri_rxdata_top.sv
//--------------------------------------------------------------------
// CPRI receive side
// per-lane unpack, lane de-skew FIFOs and header agreement check,
// presents one aligned four-antenna vector per pop
//--------------------------------------------------------------------
`include "pusch_dr_params.svh"

module cpri_rxdata_top
    import cpri_pkg::*;
    import dr_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  cpri_rx_t    i_l0_rx,
    input  cpri_rx_t    i_l1_rx,
    output pkt_info_t   o_info,
    output logic        o_ant_vld,
    output ant_vec_t    o_ant,
    output logic        o_ant_last,
    output logic        o_align_err     // sticky until reset
);

    localparam int AW = $clog2(`DR_SKEW_DEPTH);

    cpri_rx_t  [`DR_LANES-1:0]          rx;
    logic      [`DR_LANES-1:0]          hdr_vld;
    cpri_hdr_t [`DR_LANES-1:0]          hdr;
    cpri_hdr_t [`DR_LANES-1:0]          hdr_q;
    logic      [`DR_LANES-1:0]          hdr_got;
    logic      [`DR_LANES-1:0]          iq_vld;
    logic      [`DR_LANES-1:0][63:0]    iq_data;
    logic      [`DR_LANES-1:0]          iq_last;
    logic      [`DR_LANES-1:0]          nempty;
    logic      [`DR_LANES-1:0]          ovf;
    logic      [`DR_LANES-1:0][64:0]    head;       // {last, word}
    logic                               pop;

    assign rx  = {i_l1_rx, i_l0_rx};
    assign pop = &nempty;   // all lanes hold a word

    //----------------------------------------------------------------
    // per-lane unpack and de-skew FIFO
    //----------------------------------------------------------------
    for (genvar l = 0; l < `DR_LANES; l++) begin : g_lane
        logic [64:0]   mem [`DR_SKEW_DEPTH];
        logic [AW-1:0] wp;
        logic [AW-1:0] rp;
        logic [AW:0]   cnt;
        logic          wr;

        cpri_rx_unpack u_unpack (
            .i_clk      (i_clk),
            .i_rst_n    (i_rst_n),
            .i_rx       (rx[l]),
            .o_hdr_vld  (hdr_vld[l]),
            .o_hdr      (hdr[l]),
            .o_iq_vld   (iq_vld[l]),
            .o_iq_data  (iq_data[l]),
            .o_iq_last  (iq_last[l])
        );

        assign ovf[l]    = iq_vld[l] & (cnt == `DR_SKEW_DEPTH) & ~pop;
        assign wr        = iq_vld[l] & ~ovf[l];
        assign nempty[l] = (cnt != '0);
        assign head[l]   = mem[rp];

        always_ff @(posedge i_clk) begin
            if (wr)
                mem[wp] <= {iq_last[l], iq_data[l]};
        end

        always_ff @(posedge i_clk) begin
            if (!i_rst_n) begin
                wp  <= '0;
                rp  <= '0;
                cnt <= '0;
            end else begin
                if (wr)
                    wp <= wp + 1'b1;
                if (pop)
                    rp <= rp + 1'b1;
                cnt <= cnt + wr - pop;
            end
        end
    end

    //----------------------------------------------------------------
    // aligned output
    //----------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_ant_vld  <= 1'b0;
            o_ant_last <= 1'b0;
        end else begin
            o_ant_vld  <= pop;
            o_ant_last <= pop & head[0][64];    // lanes end together
        end
    end

    always_ff @(posedge i_clk) begin
        if (pop) begin
            for (int l = 0; l < `DR_LANES; l++)
                for (int a = 0; a < `DR_ANT_PER_LANE; a++)
                    o_ant[l*`DR_ANT_PER_LANE+a] <= head[l][a*32 +: 32];
        end
    end

    // header latch and lane compare
    always_ff @(posedge i_clk) begin
        for (int l = 0; l < `DR_LANES; l++)
            if (hdr_vld[l])
                hdr_q[l] <= hdr[l];
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            hdr_got     <= '0;
            o_align_err <= 1'b0;
        end else begin
            hdr_got <= (&hdr_got) ? hdr_vld : (hdr_got | hdr_vld);
            if (((&hdr_got) && (hdr_q[1] != hdr_q[0])) || (|ovf))
                o_align_err <= 1'b1;
        end
    end

    assign o_info = '{pkg_type: hdr_q[0].pkg_type, slot_idx: hdr_q[0].slot_idx,
                      symb_idx: hdr_q[0].symb_idx, cell_idx: hdr_q[0].cell_idx,
                      fft_agc:  hdr_q[0].fft_agc};

endmodule

//--- src/pusch_dr_core.sv
//--------------------------------------------------------------------
// PUSCH dimension reduction core
// two-stage fixed beam combiner, RBG framing and per-beam power sums
//--------------------------------------------------------------------
`include "pusch_dr_params.svh"

module pusch_dr_core
    import dr_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic [1:0]  i_rbg_size,     // 0:4 1:8 else 16 samples
    input  pkt_info_t   i_info,
    input  logic        i_ant_vld,
    input  ant_vec_t    i_ant,
    input  logic        i_ant_last,
    output logic        o_dr_vld,
    output beam_vec_t   o_dr_data,
    output logic        o_dr_sop,
    output logic        o_dr_eop,
    output logic        o_rbg_load,
    output logic [3:0]  o_rbg_idx,
    output logic [`DR_BEAM-1:0][`DR_PWR_W-1:0] o_beam_pwr,
    output pkt_info_t   o_info
);

    localparam int SUM_W = `DR_IQ_W + 2;

    logic signed [SUM_W-1:0] cmb_i [`DR_BEAM];
    logic signed [SUM_W-1:0] cmb_q [`DR_BEAM];
    logic signed [SUM_W-1:0] sum_i [`DR_BEAM];
    logic signed [SUM_W-1:0] sum_q [`DR_BEAM];
    logic [3:0]  rbg_last;          // last sample index in an RBG
    logic [3:0]  smp_cnt;
    logic [3:0]  rbg_cnt;
    logic        eop_now;
    logic        vld1, sop1, eop1;
    logic [3:0]  idx1;
    pkt_info_t   info1;

    function automatic logic [`DR_PWR_W-1:0] iq_pwr(input iq_t s);
        logic signed [2*`DR_IQ_W-1:0] ii;
        logic signed [2*`DR_IQ_W-1:0] qq;
        ii = s.i * s.i;
        qq = s.q * s.q;
        return ii + qq;
    endfunction

    always_comb begin
        case (i_rbg_size)
            2'd0:    rbg_last = 4'd3;
            2'd1:    rbg_last = 4'd7;
            default: rbg_last = 4'd15;
        endcase
    end

    // beam 0 adds all antennas, beam 1 subtracts the odd ones
    always_comb begin
        for (int b = 0; b < `DR_BEAM; b++) begin
            cmb_i[b] = '0;
            cmb_q[b] = '0;
            for (int a = 0; a < `DR_ANT; a++) begin
                if (b == 1 && a[0]) begin
                    cmb_i[b] = cmb_i[b] - i_ant[a].i;
                    cmb_q[b] = cmb_q[b] - i_ant[a].q;
                end else begin
                    cmb_i[b] = cmb_i[b] + i_ant[a].i;
                    cmb_q[b] = cmb_q[b] + i_ant[a].q;
                end
            end
        end
    end

    assign eop_now = (smp_cnt == rbg_last) || i_ant_last;

    //----------------------------------------------------------------
    // stage 1: sums and framing
    //----------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            vld1    <= 1'b0;
            smp_cnt <= '0;
            rbg_cnt <= '0;
        end else begin
            vld1 <= i_ant_vld;
            if (i_ant_vld) begin
                smp_cnt <= eop_now ? 4'd0 : smp_cnt + 1'b1;
                if (eop_now)
                    rbg_cnt <= i_ant_last ? 4'd0 : rbg_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_ant_vld) begin
            sum_i <= cmb_i;
            sum_q <= cmb_q;
            sop1  <= (smp_cnt == '0);
            eop1  <= eop_now;
            idx1  <= rbg_cnt;
            info1 <= i_info;
        end
    end

    //----------------------------------------------------------------
    // stage 2: shift to output width
    //----------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_dr_vld   <= 1'b0;
            o_dr_sop   <= 1'b0;
            o_dr_eop   <= 1'b0;
            o_rbg_load <= 1'b0;
        end else begin
            o_dr_vld   <= vld1;
            o_dr_sop   <= vld1 & sop1;
            o_dr_eop   <= vld1 & eop1;
            o_rbg_load <= o_dr_vld & o_dr_eop;  // sums complete next cycle
        end
    end

    always_ff @(posedge i_clk) begin
        if (vld1) begin
            for (int b = 0; b < `DR_BEAM; b++) begin
                o_dr_data[b].i <= `DR_IQ_W'(sum_i[b] >>> 2);
                o_dr_data[b].q <= `DR_IQ_W'(sum_q[b] >>> 2);
            end
            o_rbg_idx <= idx1;
            o_info    <= info1;
        end
    end

    // power per RBG, restarts on sop
    always_ff @(posedge i_clk) begin
        if (o_dr_vld) begin
            for (int b = 0; b < `DR_BEAM; b++)
                o_beam_pwr[b] <= (o_dr_sop ? '0 : o_beam_pwr[b]) + iq_pwr(o_dr_data[b]);
        end
    end

endmodule

//--- src/cpri_txdata_top.sv
//--------------------------------------------------------------------
// CPRI transmit side
// lane 0 carries beam samples, lane 1 carries packet header and
// per-RBG power words with a one-entry header holding register
//--------------------------------------------------------------------
`include "pusch_dr_params.svh"

module cpri_txdata_top
    import cpri_pkg::*;
    import dr_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_iq_tx_enable,
    input  logic        i_dr_vld,
    input  beam_vec_t   i_dr_data,
    input  logic        i_dr_sop,
    input  logic        i_rbg_load,
    input  logic [3:0]  i_rbg_idx,
    input  logic [`DR_BEAM-1:0][`DR_PWR_W-1:0] i_beam_pwr,
    input  pkt_info_t   i_info,
    output cpri_tx_t    o_cpri0_tx,
    output cpri_tx_t    o_cpri1_tx
);

    logic        tx0_vld;
    logic [63:0] tx0_data;
    logic        tx1_vld;
    logic [63:0] tx1_data;
    logic        hdr_req;
    logic        pwr_req;
    logic        hdr_pend;          // header waiting behind a power word
    cpri_hdr_t   pend_hdr;
    cpri_hdr_t   new_hdr;

    assign hdr_req = i_iq_tx_enable & i_dr_sop & (i_rbg_idx == '0);
    assign pwr_req = i_iq_tx_enable & i_rbg_load;

    assign new_hdr = '{pkg_type: i_info.pkg_type, slot_idx: i_info.slot_idx,
                       symb_idx: i_info.symb_idx, cell_idx: i_info.cell_idx,
                       fft_agc:  i_info.fft_agc,  iq_cnt:   '0, rsvd: '0};

    //----------------------------------------------------------------
    // lane 0 beam data
    //----------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n)
            tx0_vld <= 1'b0;
        else
            tx0_vld <= i_iq_tx_enable & i_dr_vld;
    end

    always_ff @(posedge i_clk) begin
        if (i_dr_vld)
            tx0_data <= i_dr_data;  // beam 0 in low half
    end

    //----------------------------------------------------------------
    // lane 1 header and power
    //----------------------------------------------------------------
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            tx1_vld  <= 1'b0;
            hdr_pend <= 1'b0;
        end else begin
            tx1_vld <= 1'b0;
            if (!i_iq_tx_enable) begin
                hdr_pend <= 1'b0;
            end else if (pwr_req) begin
                tx1_vld  <= 1'b1;
                tx1_data <= {i_beam_pwr[1], i_beam_pwr[0]};
                if (hdr_req) begin
                    hdr_pend <= 1'b1;   // header goes next cycle
                    pend_hdr <= new_hdr;
                end
            end else if (hdr_pend) begin
                tx1_vld  <= 1'b1;
                tx1_data <= pend_hdr;
                hdr_pend <= hdr_req;
                pend_hdr <= new_hdr;
            end else if (hdr_req) begin
                tx1_vld  <= 1'b1;
                tx1_data <= new_hdr;
            end
        end
    end

    assign o_cpri0_tx = '{data: tx0_data, vld: tx0_vld};
    assign o_cpri1_tx = '{data: tx1_data, vld: tx1_vld};

endmodule

//--- src/pusch_dr_top.sv
//--------------------------------------------------------------------
// PUSCH dimension reduction top level
// receive alignment, beam core and transmit repack
//--------------------------------------------------------------------
`include "pusch_dr_params.svh"

module pusch_dr_top
    import cpri_pkg::*;
    import dr_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic [1:0]  i_rbg_size,     // 2 selects 16-sample RBG
    input  cpri_rx_t    i_l0_rx,
    input  cpri_rx_t    i_l1_rx,
    input  logic        i_iq_tx_enable,
    output cpri_tx_t    o_cpri0_tx,     // beam data
    output cpri_tx_t    o_cpri1_tx,     // header and power
    output logic        o_align_err
);

    pkt_info_t   rx_info;
    logic        ant_vld;
    ant_vec_t    ant;
    logic        ant_last;
    logic        dr_vld;
    beam_vec_t   dr_data;
    logic        dr_sop;
    logic        dr_eop;
    logic        rbg_load;
    logic [3:0]  rbg_idx;
    pkt_info_t   dr_info;
    logic [`DR_BEAM-1:0][`DR_PWR_W-1:0] beam_pwr;

    cpri_rxdata_top u_rxdata (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_l0_rx        (i_l0_rx),
        .i_l1_rx        (i_l1_rx),
        .o_info         (rx_info),
        .o_ant_vld      (ant_vld),
        .o_ant          (ant),
        .o_ant_last     (ant_last),
        .o_align_err    (o_align_err)
    );

    pusch_dr_core u_core (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_rbg_size     (i_rbg_size),
        .i_info         (rx_info),
        .i_ant_vld      (ant_vld),
        .i_ant          (ant),
        .i_ant_last     (ant_last),
        .o_dr_vld       (dr_vld),
        .o_dr_data      (dr_data),
        .o_dr_sop       (dr_sop),
        .o_dr_eop       (dr_eop),
        .o_rbg_load     (rbg_load),
        .o_rbg_idx      (rbg_idx),
        .o_beam_pwr     (beam_pwr),
        .o_info         (dr_info)
    );

    cpri_txdata_top u_txdata (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_iq_tx_enable (i_iq_tx_enable),
        .i_dr_vld       (dr_vld),
        .i_dr_data      (dr_data),
        .i_dr_sop       (dr_sop),
        .i_rbg_load     (rbg_load),
        .i_rbg_idx      (rbg_idx),
        .i_beam_pwr     (beam_pwr),
        .i_info         (dr_info),
        .o_cpri0_tx     (o_cpri0_tx),
        .o_cpri1_tx     (o_cpri1_tx)
    );

endmodule

//--- tests/tb_clk_gen.sv
//--------------------------------------------------------------------
// testbench clock and power-on reset
// free running clock, reset held low for a number of rising edges
//--------------------------------------------------------------------
module tb_clk_gen #(
    parameter int PERIOD  = 20,         // ns
    parameter int RST_CYC = 5
) (
    output logic o_clk,
    output logic o_rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYC) @(posedge o_clk);
        @(negedge o_clk);                   // release between edges
        o_rst_n = 1'b1;
    end

endmodule

//--- tests/pusch_dr_properties.sv
//--------------------------------------------------------------------
// PUSCH dimension reduction properties
// reset, sticky error, RBG load timing and tx enable gating
//--------------------------------------------------------------------
module pusch_dr_properties
    import cpri_pkg::*;
(
    input logic     i_clk,
    input logic     i_rst_n,
    input logic     i_iq_tx_enable,
    input cpri_tx_t i_cpri0_tx,
    input cpri_tx_t i_cpri1_tx,
    input logic     i_align_err,
    input logic     i_dr_eop,
    input logic     i_rbg_load
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_cnt = 0;      // assertion failures so far

    a_tx_idle_in_reset: assert property (@(posedge i_clk)
        !i_rst_n |=> !i_cpri0_tx.vld && !i_cpri1_tx.vld)
        else begin
            $error("tx valid high right after a reset cycle");
            fail_cnt++;
        end

    a_err_sticky: assert property (@(posedge i_clk)
        i_rst_n && i_align_err |=> i_align_err)
        else begin
            $error("align error fell without reset");
            fail_cnt++;
        end

    a_load_after_eop: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_dr_eop |=> i_rbg_load)
        else begin
            $error("no rbg load one cycle after eop");
            fail_cnt++;
        end

    a_no_tx_when_off: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_iq_tx_enable |=> !i_cpri1_tx.vld && !i_cpri0_tx.vld)
        else begin
            $error("tx word sent while tx enable low");
            fail_cnt++;
        end

endmodule

bind pusch_dr_top pusch_dr_properties u_props (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_iq_tx_enable (i_iq_tx_enable),
    .i_cpri0_tx     (o_cpri0_tx),
    .i_cpri1_tx     (o_cpri1_tx),
    .i_align_err    (o_align_err),
    .i_dr_eop       (dr_eop),
    .i_rbg_load     (rbg_load)
);

//--- tests/pusch_dr_tb.sv
//--------------------------------------------------------------------
// PUSCH dimension reduction testbench
// directed packet tests with a reference model of the beam sums,
// per-RBG power words and the tx header layout
//--------------------------------------------------------------------
module pusch_dr_tb
    import cpri_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          TOTAL_WORDS = 124;      // IQ words over all tests
    localparam int          TIMEOUT_CYC = TOTAL_WORDS * 40 + 400;
    localparam logic [31:0] LFSR_TAPS   = 32'h8020_0003;
    localparam logic [23:0] SLOT_LSB    = 24'h00_2000;

    logic        clk;
    logic        por_rst_n;
    logic        tb_rst_n;
    logic        rst_n;
    logic [1:0]  rbg_size;
    logic        tx_en;
    cpri_rx_t    l0_rx;
    cpri_rx_t    l1_rx;
    cpri_tx_t    tx0;
    cpri_tx_t    tx1;
    logic        align_err;

    cpri_rx_t    sched0[$];             // per-cycle lane words
    cpri_rx_t    sched1[$];
    logic [63:0] exp0[$];
    logic [63:0] exp1[$];
    logic [63:0] got0[$];
    logic [63:0] got1[$];
    logic [31:0] lfsr = 32'hcb9a;
    int          test_errs = 0;
    int          total_errs = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    assign rst_n = por_rst_n & tb_rst_n;

    tb_clk_gen #(.PERIOD(20), .RST_CYC(5)) u_clk_gen (
        .o_clk   (clk),
        .o_rst_n (por_rst_n)
    );

    pusch_dr_top u_dut (
        .i_clk          (clk),
        .i_rst_n        (rst_n),
        .i_rbg_size     (rbg_size),
        .i_l0_rx        (l0_rx),
        .i_l1_rx        (l1_rx),
        .i_iq_tx_enable (tx_en),
        .o_cpri0_tx     (tx0),
        .o_cpri1_tx     (tx1),
        .o_align_err    (align_err)
    );

    // outputs move on the rising edge
    always @(negedge clk) begin
        if (tx0.vld === 1'b1)
            got0.push_back(tx0.data);
        if (tx1.vld === 1'b1)
            got1.push_back(tx1.data);
    end

    //----------------------------------------------------------------
    // stimulus and reference model
    //----------------------------------------------------------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic int rbg_len(input logic [1:0] sel);
        return (sel == 2'd0) ? 4 : ((sel == 2'd1) ? 8 : 16);
    endfunction

    // info is {type, slot, symbol, cell, agc}
    task automatic add_packet(input logic [23:0] info, input int n, input bit gaps,
                              input bit skew, input bit bad_slot, input bit tx_on);
        logic [63:0] w [2];
        int          d;
        int          len;
        int          ai [4];
        int          aq [4];
        int          b0i, b0q, b1i, b1q;
        logic [31:0] pw0;
        logic [31:0] pw1;
        d   = skew ? int'(rand_bits(2)) : 0;
        len = rbg_len(rbg_size);
        pw0 = '0;
        pw1 = '0;
        sched0.push_back({info, 11'(n), 29'd0, 1'b1});
        repeat (d) sched1.push_back('0);        // lane 1 lags
        sched1.push_back({info ^ (bad_slot ? SLOT_LSB : 24'd0), 11'(n), 29'd0, 1'b1});
        if (tx_on)
            exp1.push_back({info, 40'd0});      // count field zero
        for (int k = 0; k < n; k++) begin
            if (gaps) begin
                repeat (rand_bits(2)) begin
                    sched0.push_back('0);
                    sched1.push_back('0);
                end
            end
            w[0] = {rand_bits(32), rand_bits(32)};
            w[1] = {rand_bits(32), rand_bits(32)};
            sched0.push_back({w[0], 1'b1});
            sched1.push_back({w[1], 1'b1});
            for (int a = 0; a < 4; a++) begin
                ai[a] = $signed(w[a / 2][(a % 2) * 32 + 16 +: 16]);   // I above Q
                aq[a] = $signed(w[a / 2][(a % 2) * 32 +: 16]);
            end
            b0i = (ai[0] + ai[1] + ai[2] + ai[3]) >>> 2;
            b0q = (aq[0] + aq[1] + aq[2] + aq[3]) >>> 2;
            b1i = (ai[0] - ai[1] + ai[2] - ai[3]) >>> 2;
            b1q = (aq[0] - aq[1] + aq[2] - aq[3]) >>> 2;
            if (tx_on)
                exp0.push_back({16'(b1i), 16'(b1q), 16'(b0i), 16'(b0q)});
            if (k % len == 0) begin
                pw0 = '0;
                pw1 = '0;
            end
            pw0 = pw0 + 32'(b0i * b0i) + 32'(b0q * b0q);    // wraps mod 2^32
            pw1 = pw1 + 32'(b1i * b1i) + 32'(b1q * b1q);
            if (tx_on && ((k % len == len - 1) || (k == n - 1)))
                exp1.push_back({pw1, pw0});
        end
        repeat (d) sched0.push_back('0);        // lanes end level
    endtask

    task automatic drive_sched();
        while (sched0.size() != 0 || sched1.size() != 0) begin
            @(negedge clk);
            l0_rx = (sched0.size() != 0) ? sched0.pop_front() : '0;
            l1_rx = (sched1.size() != 0) ? sched1.pop_front() : '0;
        end
        @(negedge clk);
        l0_rx = '0;
        l1_rx = '0;
    endtask

    //----------------------------------------------------------------
    // checking and reporting
    //----------------------------------------------------------------
    task automatic check_out(input string name, input logic err_exp);
        while (got0.size() < exp0.size() || got1.size() < exp1.size())
            @(negedge clk);
        repeat (12) @(negedge clk);             // catch stray words
        if (got0.size() != exp0.size()) begin
            $display("Fail %s: lane 0 word count expected %0d actual %0d",
                     name, exp0.size(), got0.size());
            test_errs++;
        end
        if (got1.size() != exp1.size()) begin
            $display("Fail %s: lane 1 word count expected %0d actual %0d",
                     name, exp1.size(), got1.size());
            test_errs++;
        end
        for (int i = 0; i < exp0.size() && i < got0.size(); i++) begin
            if (got0[i] !== exp0[i]) begin
                $display("Fail %s: lane 0 word %0d expected %h actual %h",
                         name, i, exp0[i], got0[i]);
                test_errs++;
            end
        end
        for (int i = 0; i < exp1.size() && i < got1.size(); i++) begin
            if (got1[i] !== exp1[i]) begin
                $display("Fail %s: lane 1 word %0d expected %h actual %h",
                         name, i, exp1[i], got1[i]);
                test_errs++;
            end
        end
        if (align_err !== err_exp) begin
            $display("Fail %s: align error expected %b actual %b", name, err_exp, align_err);
            test_errs++;
        end
        exp0.delete();
        exp1.delete();
        got0.delete();
        got1.delete();
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: %0d errors", name, test_errs);
            tests_failed++;
        end
        total_errs += test_errs;
        test_errs = 0;
    endtask

    //----------------------------------------------------------------
    // directed tests
    //----------------------------------------------------------------
    task automatic test_aligned_rbg16();
        rbg_size = 2'd2;
        add_packet({4'd0, 7'd12, 4'd3, 1'b0, 8'h40}, 32, 0, 0, 0, 1);
        drive_sched();
        check_out("aligned_rbg16", 1'b0);
        finish_test("aligned_rbg16");
    endtask

    task automatic test_gaps_skew_rbg4();
        rbg_size = 2'd0;
        add_packet({4'd0, 7'd33, 4'd7, 1'b1, 8'h1c}, 32, 1, 1, 0, 1);
        drive_sched();
        check_out("gaps_skew_rbg4", 1'b0);
        finish_test("gaps_skew_rbg4");
    endtask

    task automatic test_partial_rbg8();
        rbg_size = 2'd1;
        add_packet({4'd2, 7'd5, 4'd11, 1'b0, 8'h9a}, 10, 0, 0, 0, 1);
        drive_sched();
        check_out("partial_rbg8", 1'b0);
        finish_test("partial_rbg8");
    endtask

    task automatic test_back_to_back();
        rbg_size = 2'd0;
        add_packet({4'd1, 7'd70, 4'd2, 1'b1, 8'h55}, 16, 1, 0, 0, 1);
        add_packet({4'd2, 7'd71, 4'd9, 1'b0, 8'haa}, 12, 1, 0, 0, 1);
        drive_sched();
        check_out("back_to_back", 1'b0);
        finish_test("back_to_back");
    endtask

    task automatic test_tx_disable();
        rbg_size = 2'd1;
        tx_en    = 1'b0;
        add_packet({4'd0, 7'd90, 4'd4, 1'b0, 8'h11}, 8, 0, 0, 0, 0);
        drive_sched();
        check_out("tx_disable", 1'b0);          // nothing may appear
        tx_en = 1'b1;
        add_packet({4'd0, 7'd91, 4'd5, 1'b1, 8'h22}, 8, 1, 0, 0, 1);
        drive_sched();
        check_out("tx_disable", 1'b0);
        finish_test("tx_disable");
    endtask

    task automatic test_hdr_mismatch();
        rbg_size = 2'd2;
        add_packet({4'd1, 7'd40, 4'd6, 1'b0, 8'h77}, 6, 0, 0, 1, 1);
        drive_sched();
        check_out("hdr_mismatch", 1'b1);
        check_out("hdr_mismatch", 1'b1);        // still set later on
        tb_rst_n = 1'b0;
        repeat (2) @(negedge clk);
        tb_rst_n = 1'b1;
        check_out("hdr_mismatch", 1'b0);
        finish_test("hdr_mismatch");
    endtask

    initial begin
        l0_rx    = '0;
        l1_rx    = '0;
        rbg_size = 2'd2;
        tx_en    = 1'b1;
        tb_rst_n = 1'b1;
        wait (por_rst_n === 1'b1);
        @(negedge clk);
        test_aligned_rbg16();
        test_gaps_skew_rbg4();
        test_partial_rbg8();
        test_back_to_back();
        test_tx_disable();
        test_hdr_mismatch();
        $display("tests run %0d, tests failed %0d, mismatches %0d, assertion failures %0d",
                 tests_run, tests_failed, total_errs, u_dut.u_props.fail_cnt);
        if (tests_failed == 0 && u_dut.u_props.fail_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // watchdog, sized from the total packet length
    initial begin
        repeat (TIMEOUT_CYC) @(posedge clk);
        $display("watchdog expired after %0d cycles, expected output never arrived",
                 TIMEOUT_CYC);
        $display("Test failed");
        $finish;
    end

endmodule

//--- sim.f
+incdir+src
src/cpri_pkg.sv
src/dr_pkg.sv
src/cpri_rx_unpack.sv
src/cpri_rxdata_top.sv
src/pusch_dr_core.sv
src/cpri_txdata_top.sv
src/pusch_dr_top.sv
tests/tb_clk_gen.sv
tests/pusch_dr_properties.sv
tests/pusch_dr_tb.sv
